// File: Bender.yml
package:
  name: cpu16

sources:
  - verilog/cpuPkg.sv
  - verilog/decodeIf.sv
  - verilog/commitIf.sv
  - verilog/instrDecode.sv
  - verilog/execUnit.sv
  - verilog/commitUnit.sv
  - verilog/cpuTop.sv
  - target: test
    files:
      - dv/tbCpu.sv

// File: dv/tbCpu.sv
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

	localparam int period = 4; // ns.
	localparam int ldiStop = 24; // commits before each debug stop.
	localparam int midStop = 30;
	localparam int endStop = 60;
	localparam int randCount = 40; // random MOVI and ALU words.
	localparam int timeoutNs = (2 * (ldiStop + endStop) * 4 + 2 * 3) * period;

	logic clkX1, rstN, debugStop, storeEn;
	logic stoppedN, fetchN, decodeN, executeN, commitN;
	dataWord instrAddr, instrData, storeAddr, storeData, dbgRegData;
	regIdx dbgRegAddr;

	dataWord imem [256]; // word addressed.
	dataWord mRegs [regCount]; // model register file.
	dataWord mPc; // model program counter.
	phaseE expPh;
	logic armed; // set at the first fetch after reset.
	logic expSt;
	dataWord expAddr, expData;
	int commits;
	int stores;
	logic [15:0] lfsr;

	cpuTop u_cpuTop (.*);

	assign instrData = imem[instrAddr[7:0]]; // same-cycle answer.

	initial begin
		clkX1 = 1'b0;
		forever #(period / 2) clkX1 = ~clkX1;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken.
	function automatic logic [11:0] randBits(int n);
		logic [11:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[10:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic failNow(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWord(string name, dataWord act, dataWord exp);
		if (act !== exp) begin
			failNow($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
		end
	endtask

	// strobes in the order fetch, decode, execute, commit, stopped.
	task automatic checkPhase(phaseE exp);
		logic [4:0] want;
		logic [4:0] got;
		want = ~(5'b10000 >> exp);
		got = {fetchN, decodeN, executeN, commitN, stoppedN};
		if (got !== want) begin
			failNow($sformatf("Fail at %0t: phase strobes in %s expected %b got %b",
				$time, exp.name(), want, got));
		end
	endtask

	task automatic checkStore(logic expEn, dataWord expA, dataWord expD);
		if (storeEn !== expEn) begin
			failNow($sformatf("Fail at %0t: storeEn expected %b got %b", $time, expEn, storeEn));
		end
		if (expEn && ({storeAddr, storeData} !== {expA, expD})) begin
			failNow($sformatf("Fail at %0t: storeAddr/storeData expected %h/%h got %h/%h",
				$time, expA, expD, storeAddr, storeData));
		end
	endtask

	// runs the instruction at mPc on the model, straight from the encoding rules.
	function automatic void refStep(output logic st, output dataWord sAddr, output dataWord sData);
		dataWord w;
		dataWord rsVal;
		dataWord rdVal;
		w = imem[mPc[7:0]];
		rsVal = mRegs[w[7:4]];
		rdVal = mRegs[w[3:0]];
		st = 1'b0;
		sAddr = rdVal; // address in rd.
		sData = rsVal;
		mPc = mPc + 16'd1;
		case (w[15:12])
			4'd1: mRegs[w[11:8]] = {8'h00, w[7:0]}; // MOVI, zero-extended.
			4'd4: begin
				mRegs[w[3:0]] = imem[mPc[7:0]]; // mPc already on the immediate word.
				mPc = mPc + 16'd1;
			end
			4'd5: st = 1'b1; // ST, registers untouched.
			4'd8: mPc = {8'h00, w[7:0]};
			4'd12: begin
				case (w[11:8])
					4'd0: mRegs[w[3:0]] = rsVal;
					4'd1: mRegs[w[3:0]] = rdVal + rsVal;
					4'd2: mRegs[w[3:0]] = rdVal - rsVal;
					4'd3: mRegs[w[3:0]] = rdVal & rsVal;
					4'd4: mRegs[w[3:0]] = rdVal | rsVal;
					4'd5: mRegs[w[3:0]] = rdVal ^ rsVal;
					default: mRegs[w[3:0]] = rdVal;
				endcase
			end
			default: st = 1'b0; // no-op.
		endcase
	endfunction

	task automatic fillMemory();
		for (int a = 0; a < 256; a++) begin
			imem[a] = {8'h00, 8'(a)}; // opcode 0 runs as a no-op.
		end
	endtask

	task automatic buildLdiProgram();
		fillMemory();
		for (int r = 0; r < regCount; r++) begin
			imem[2 * r] = {opLdi, 8'h00, regIdx'(r)};
			imem[2 * r + 1] = (r == 0) ? 16'h0011 : 16'(r * 16'h1111);
		end
		imem[32] = {opJpi, 4'h0, 8'h40};
		imem[64] = {opJpi, 4'h0, 8'h40}; // spins here.
	endtask

	task automatic buildRandomProgram();
		logic kind;
		logic [11:0] fld;
		fillMemory();
		for (int k = 0; k < randCount; k++) begin
			kind = (randBits(1) != '0);
			fld = randBits(12);
			imem[k] = kind ? {opMovi, fld} : {opAlu, 1'b0, fld[10:0]}; // funcs 6 and 7 keep rd.
		end
		for (int r = 0; r < regCount; r++) begin
			imem[randCount + r] = {opSt, 4'h0, regIdx'(r), regIdx'(regCount - 1 - r)};
		end
		imem[randCount + regCount] = {opJpi, 4'h0, 8'(randCount + regCount)};
	endtask

	// called on a falling edge, or at time zero.
	task automatic resetCore();
		rstN = 1'b0;
		debugStop = 1'b0;
		armed = 1'b0;
		expPh = phFetch;
		mPc = '0;
		commits = 0;
		stores = 0;
		foreach (mRegs[i]) begin
			mRegs[i] = '0;
		end
		repeat (3) @(posedge clkX1); // three reset cycles.
		@(negedge clkX1);
		rstN = 1'b1;
	endtask

	// raise debugStop during an execute, then read all registers once parked.
	task automatic stopAndCheck(int count);
		wait (commits >= count);
		do @(negedge clkX1); while (executeN);
		debugStop = 1'b1;
		do @(negedge clkX1); while (stoppedN);
		for (int i = 0; i < regCount; i++) begin
			dbgRegAddr = regIdx'(i);
			@(posedge clkX1);
			checkWord("dbgRegData", dbgRegData, mRegs[i]);
			@(negedge clkX1);
		end
	endtask

	// compare, sampled at the rising edge before anything updates.
	always @(posedge clkX1) begin
		expSt = 1'b0;
		if (!rstN) begin
			armed = 1'b0;
		end else if (armed || !fetchN) begin
			armed = 1'b1;
			checkPhase(expPh);
			case (expPh)
				phFetch: begin
					checkWord("instrAddr", instrAddr, mPc);
					expPh = phDecode;
				end
				phDecode: begin
					checkWord("instrAddr", instrAddr,
						(imem[mPc[7:0]][15:12] == 4'd4) ? mPc + 16'd1 : mPc); // LDI immediate.
					expPh = phExecute;
				end
				phExecute: expPh = phCommit;
				phCommit: begin
					refStep(expSt, expAddr, expData);
					commits++;
					expPh = debugStop ? phStopped : phFetch;
				end
				default: begin
					checkWord("instrAddr", instrAddr, mPc); // holds the next pc.
					expPh = debugStop ? phStopped : phFetch;
				end
			endcase
			checkStore(expSt, expAddr, expData);
			if (storeEn) begin
				stores++;
			end
		end
	end

	initial begin
		#(timeoutNs);
		failNow("Timed out: the core did not get through the programs in time");
	end

	initial begin
		rstN = 1'b0;
		debugStop = 1'b0;
		dbgRegAddr = '0;
		lfsr = 16'd54;
		buildLdiProgram();
		resetCore();
		stopAndCheck(ldiStop); // sixteen LDI, a jump, then the loop.
		buildRandomProgram(); // core stays parked meanwhile.
		resetCore();
		stopAndCheck(midStop);
		debugStop = 1'b0;
		stopAndCheck(endStop);
		if (stores != regCount) begin
			failNow($sformatf("Saw %0d stores but the program holds %0d", stores, regCount));
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: tb.f
verilog/cpuPkg.sv
verilog/decodeIf.sv
verilog/commitIf.sv
verilog/instrDecode.sv
verilog/execUnit.sv
verilog/commitUnit.sv
verilog/cpuTop.sv
dv/tbCpu.sv

// File: verilog/commitIf.sv
`timescale 1ns/1ps

// two operand reads, answered in the same cycle.
interface regPortIf import cpuPkg::*; ();

	regIdx addrA; // rs.
	regIdx addrB; // rd.
	dataWord dataA;
	dataWord dataB;

	modport requester (output addrA, addrB, input dataA, dataB);
	modport responder (input addrA, addrB, output dataA, dataB);

endinterface

interface commitIf import cpuPkg::*; ();

	logic valid; // high for the commit cycle only.
	logic writeEn;
	regIdx rd;
	dataWord value;
	logic storeEn;
	dataWord storeAddr;
	dataWord storeData;
	logic jumpEn;
	dataWord jumpTarget;

	modport producer (
		output valid, writeEn, rd, value,
		output storeEn, storeAddr, storeData,
		output jumpEn, jumpTarget
	);
	modport writeback (input valid, writeEn, rd, value, storeEn, storeAddr, storeData);
	modport jump (input valid, jumpEn, jumpTarget);

endinterface

// File: verilog/commitUnit.sv
`timescale 1ns/1ps

module commitUnit import cpuPkg::*; (
	input  logic    clkX1,
	input  logic    rstN,
	input  regIdx   dbgRegAddr,
	output dataWord dbgRegData,
	output logic    storeEn,
	output dataWord storeAddr,
	output dataWord storeData,
	regPortIf.responder rp,
	commitIf.writeback  res
);

	dataWord regs [regCount]; // R0 to R15.

	// write-back lands at the end of the commit cycle.
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (res.valid && res.writeEn) begin
			regs[res.rd] <= res.value;
		end
	end

	// three combinational read ports.
	assign rp.dataA = regs[rp.addrA];
	assign rp.dataB = regs[rp.addrB];
	assign dbgRegData = regs[dbgRegAddr]; // shows the new value from the cycle after commit.

	// store goes straight out during commit.
	assign storeEn = res.valid && res.storeEn;
	assign storeAddr = res.storeAddr;
	assign storeData = res.storeData;

	// execute must only raise a store inside a commit.
	assert property (@(posedge clkX1) disable iff (!rstN)
		res.storeEn |-> res.valid);

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16; // data word and instruction word.
	localparam int regCount = 16; // general registers R0 to R15.
	localparam int regIdxWidth = $clog2(regCount);
	localparam int opWidth = 4; // major opcode in bits 15 to 12.
	localparam int funcWidth = 4;
	localparam int immWidth = 8; // short immediate of MOVI and JPI.

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [regIdxWidth-1:0] regIdx;

	// major opcodes, anything else runs as a no-op.
	typedef enum logic [opWidth-1:0] {
		opMovi = 4'd1,
		opLdi = 4'd4, // immediate comes from the next word.
		opSt = 4'd5,
		opJpi = 4'd8,
		opAlu = 4'd12
	} opcodeE;

	// register to register functions, rd is both operand and result.
	typedef enum logic [funcWidth-1:0] {
		fnMov = 4'd0,
		fnAdd = 4'd1,
		fnSub = 4'd2, // rd minus rs.
		fnAnd = 4'd3,
		fnOr = 4'd4,
		fnXor = 4'd5
	} aluFuncE;

	typedef enum logic [2:0] {
		phFetch,
		phDecode,
		phExecute,
		phCommit,
		phStopped // parked between instructions by the debugger.
	} phaseE;

	// one instruction word, read in the form its opcode calls for.
	typedef union packed {
		struct packed {
			opcodeE opcode;
			aluFuncE func;
			regIdx rs;
			regIdx rd;
		} r; // ALU, LDI and ST.
		struct packed {
			opcodeE opcode;
			regIdx rd;
			logic [immWidth-1:0] imm8;
		} i; // MOVI and JPI.
	} instrU;

endpackage

// File: verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
	parameter dataWord resetPc = '0
) (
	input  logic    clkX1,
	input  logic    rstN,
	output dataWord instrAddr,
	input  dataWord instrData,
	output logic    storeEn,
	output dataWord storeAddr,
	output dataWord storeData,
	input  logic    debugStop,
	input  regIdx   dbgRegAddr,
	output dataWord dbgRegData,
	output logic    stoppedN,
	output logic    fetchN,
	output logic    decodeN,
	output logic    executeN,
	output logic    commitN
);

	decodeIf decBus ();
	regPortIf regBus ();
	commitIf resBus ();

	// sequencer, fetch and decode.
	instrDecode #(
		.resetPc(resetPc)
	) u_instrDecode (
		.clkX1(clkX1),
		.rstN(rstN),
		.instrData(instrData),
		.debugStop(debugStop),
		.instrAddr(instrAddr),
		.stoppedN(stoppedN),
		.fetchN(fetchN),
		.decodeN(decodeN),
		.executeN(executeN),
		.commitN(commitN),
		.dec(decBus.producer),
		.res(resBus.jump)
	);

	execUnit u_execUnit (
		.clkX1(clkX1),
		.rstN(rstN),
		.dec(decBus.consumer),
		.rp(regBus.requester),
		.res(resBus.producer)
	);

	// register file and store port.
	commitUnit u_commitUnit (
		.clkX1(clkX1),
		.rstN(rstN),
		.dbgRegAddr(dbgRegAddr),
		.dbgRegData(dbgRegData),
		.storeEn(storeEn),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.rp(regBus.responder),
		.res(resBus.writeback)
	);

endmodule

// File: verilog/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf import cpuPkg::*; ();

	phaseE phase; // sequencer phase, execute acts on phExecute only.
	opcodeE opcode;
	aluFuncE func;
	regIdx rd; // already picked from the right instruction form.
	regIdx rs;
	dataWord imm; // zero-extended imm8, or the LDI second word.

	modport producer (
		output phase,
		output opcode, func,
		output rd, rs,
		output imm
	);

	modport consumer (
		input phase,
		input opcode, func,
		input rd, rs,
		input imm
	);

endinterface

// File: verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
	input logic clkX1,
	input logic rstN,
	decodeIf.consumer   dec,
	regPortIf.requester rp,
	commitIf.producer   res
);

	logic isExec;
	dataWord aluOut;
	logic nextWrite;
	logic nextStore;
	logic nextJump;

	assign isExec = (dec.phase == phExecute);

	// rs on port A, rd on port B.
	assign rp.addrA = dec.rs;
	assign rp.addrB = dec.rd;

	always_comb begin
		case (dec.func)
			fnMov: aluOut = rp.dataA;
			fnAdd: aluOut = rp.dataB + rp.dataA;
			fnSub: aluOut = rp.dataB - rp.dataA; // rd minus rs.
			fnAnd: aluOut = rp.dataB & rp.dataA;
			fnOr: aluOut = rp.dataB | rp.dataA;
			fnXor: aluOut = rp.dataB ^ rp.dataA;
			default: aluOut = rp.dataB; // unknown function keeps rd.
		endcase
	end

	// what the instruction does at commit.
	always_comb begin
		nextWrite = 1'b0;
		nextStore = 1'b0;
		nextJump = 1'b0;
		case (dec.opcode)
			opMovi, opLdi, opAlu: nextWrite = 1'b1;
			opSt: nextStore = 1'b1;
			opJpi: nextJump = 1'b1;
			default: nextWrite = 1'b0; // no-op.
		endcase
	end

	// control flags, one pulse after execute.
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			res.valid <= 1'b0;
			res.writeEn <= 1'b0;
			res.storeEn <= 1'b0;
			res.jumpEn <= 1'b0;
		end else begin
			res.valid <= isExec;
			res.writeEn <= isExec && nextWrite;
			res.storeEn <= isExec && nextStore;
			res.jumpEn <= isExec && nextJump;
		end
	end

	always_ff @(posedge clkX1) begin
		if (isExec) begin
			res.rd <= dec.rd;
			res.value <= (dec.opcode == opAlu) ? aluOut : dec.imm; // MOVI and LDI pass the immediate.
			res.storeAddr <= rp.dataB; // address in rd.
			res.storeData <= rp.dataA; // data in rs.
			res.jumpTarget <= dec.imm;
		end
	end

	// one result per instruction.
	assert property (@(posedge clkX1) disable iff (!rstN)
		res.valid |=> !res.valid);

	assert property (@(posedge clkX1) disable iff (!rstN)
		!(res.writeEn && res.storeEn));

endmodule

// File: verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import cpuPkg::*; #(
	parameter dataWord resetPc = '0
) (
	input  logic    clkX1,
	input  logic    rstN,
	input  dataWord instrData,
	input  logic    debugStop,
	output dataWord instrAddr,
	output logic    stoppedN,
	output logic    fetchN,
	output logic    decodeN,
	output logic    executeN,
	output logic    commitN,
	decodeIf.producer dec,
	commitIf.jump     res
);

	phaseE phase;
	logic live; // set on the first clock out of reset.
	dataWord pc; // word address of the current instruction.
	instrU instrWord;
	dataWord ldiWord; // second word of LDI.
	logic isLdi;
	logic isImmForm;

	assign isLdi = (instrWord.r.opcode == opLdi);
	assign isImmForm = (instrWord.i.opcode == opMovi) || (instrWord.i.opcode == opJpi);

	// LDI pulls its immediate from the word after it while decoding.
	assign instrAddr = (phase == phDecode && isLdi) ? pc + dataWord'(1) : pc;

	// sequencer.
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			phase <= phFetch;
			live <= 1'b0;
			pc <= resetPc;
		end else begin
			live <= 1'b1;
			if (live) begin
				case (phase)
					phFetch: phase <= phDecode;
					phDecode: phase <= phExecute;
					phExecute: phase <= phCommit;
					phCommit: begin
						if (res.valid && res.jumpEn) begin
							pc <= res.jumpTarget; // absolute, no offset.
						end else if (isLdi) begin
							pc <= pc + dataWord'(2); // skip the immediate word.
						end else begin
							pc <= pc + dataWord'(1);
						end
						phase <= debugStop ? phStopped : phFetch; // stop only between instructions.
					end
					phStopped: phase <= debugStop ? phStopped : phFetch;
					default: phase <= phFetch;
				endcase
			end
		end
	end

	// memory answers in the same cycle, so both words land at the end of the phase.
	always_ff @(posedge clkX1) begin
		if (live && phase == phFetch) begin
			instrWord <= instrData;
		end
		if (live && phase == phDecode && isLdi) begin
			ldiWord <= instrData;
		end
	end

	assign dec.phase = phase;
	assign dec.opcode = instrWord.r.opcode;
	assign dec.func = instrWord.r.func;
	assign dec.rs = instrWord.r.rs;
	assign dec.rd = isImmForm ? instrWord.i.rd : instrWord.r.rd; // rd sits in a different field.
	assign dec.imm = isLdi ? ldiWord : {{(dataWidth-immWidth){1'b0}}, instrWord.i.imm8};

	// phase strobes, all high until the core is live.
	assign fetchN = !(live && phase == phFetch);
	assign decodeN = !(phase == phDecode);
	assign executeN = !(phase == phExecute);
	assign commitN = !(phase == phCommit);
	assign stoppedN = !(phase == phStopped);

	// never two phases on the pins at once.
	assert property (@(posedge clkX1) disable iff (!rstN)
		$onehot0({~stoppedN, ~fetchN, ~decodeN, ~executeN, ~commitN}));

	// the execute result must be waiting when the commit strobe shows.
	assert property (@(posedge clkX1) disable iff (!rstN)
		!commitN |-> res.valid);

endmodule
